//--- design/serdes_pkg.sv
package serdes_pkg;

	// datapath geometry
	localparam int word_width = 5; // bits per deserialized word
	localparam int phase_width = 3; // enough for a 0..4 bit phase

	// alignment thresholds
	localparam int lock_matches = 4; // consecutive pattern hits before lock
	localparam int slip_settle_words = 2; // words skipped after each bitslip
	localparam int slip_count_width = 8; // saturating slip counter

	// counter widths inside the aligner
	localparam int match_count_width = $clog2(lock_matches); // counts 0 .. lock_matches-1
	localparam int settle_count_width = $clog2(slip_settle_words + 1);

	// aligner FSM encoding
	localparam int state_width = 2;
	localparam logic [state_width-1:0] st_idle = 2'd0; // receiver disabled
	localparam logic [state_width-1:0] st_hunting = 2'd1; // comparing words with the pattern
	localparam logic [state_width-1:0] st_settling = 2'd2; // waiting out a bitslip
	localparam logic [state_width-1:0] st_locked = 2'd3; // boundary found

endpackage

//--- design/apb_map_pkg.sv
package apb_map_pkg;

	// bus geometry
	localparam int apb_addr_width = 4;
	localparam int apb_data_width = 32;

	// register offsets
	localparam logic [apb_addr_width-1:0] reg_ctrl = 4'h0; // read/write
	localparam logic [apb_addr_width-1:0] reg_status = 4'h4; // read only
	localparam logic [apb_addr_width-1:0] reg_data = 4'h8; // read only, last valid word
	localparam logic [apb_addr_width-1:0] reg_count = 4'hC; // read only, words since lock

	// reg_ctrl fields
	localparam int ctrl_enable_bit = 0; // receiver enable
	localparam int ctrl_pattern_lsb = 8; // training pattern in bits 12:8

	// reg_status fields
	localparam int status_locked_bit = 0;
	localparam int status_slips_lsb = 8; // slip count in bits 15:8

	// reg_count is a plain wrapping counter
	localparam int count_width = 16;

endpackage

//--- design/bit_deserializer.sv
`timescale 1ns/100ps

module bit_deserializer import serdes_pkg::*; (
	input bit_clock,
	input rst_n,
	input input_bit, // serial line, msb of each word first
	input bitslip, // one-cycle pulse from the aligner
	output logic [word_width-1:0] word,
	output logic word_valid
);
	// the oldest bit in the shifter becomes the msb of the word
	logic [word_width-1:0] shift;
	logic [phase_width-1:0] phase; // bit position inside the current word
	logic wrap; // last bit of the word is in the shifter

	// a bitslip freezes the phase, so a wrap cannot happen in that cycle
	assign wrap = (phase == phase_width'(word_width - 1)) && !bitslip;

	// free running serial shifter
	always_ff @(posedge bit_clock) begin
		shift <= {shift[word_width-2:0], input_bit}; // sample every rising edge
	end

	// phase counter 0..4
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (bitslip) begin
			phase <= phase; // hold one bit time, boundary moves one bit later
		end else if (wrap) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// word strobe, one cycle wide
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= wrap; // every 5 cycles, 6 after a slip
		end
	end

	// parallel word register
	always_ff @(posedge bit_clock) begin
		if (wrap) begin
			word <= shift; // the 5 bits sampled before this edge
		end
	end

endmodule

//--- design/word_aligner.sv
`timescale 1ns/100ps

module word_aligner import serdes_pkg::*; (
	input bit_clock,
	input rst_n,
	input enable, // from reg_ctrl
	input [word_width-1:0] pattern, // training word to look for
	input [word_width-1:0] word,
	input word_valid,
	output logic bitslip, // one-cycle request to the deserializer
	output logic locked,
	output logic [slip_count_width-1:0] slip_count
);
	logic [state_width-1:0] state;
	logic [match_count_width-1:0] match_count; // consecutive hits so far
	logic [settle_count_width-1:0] settle_count; // words left to skip
	logic match;
	logic slips_full; // counter at its ceiling

	assign match = (word == pattern); // checked in the word_valid cycle
	assign slips_full = (slip_count == {slip_count_width{1'b1}});
	assign locked = (state == st_locked); // state is registered

	always_ff @(posedge bit_clock) begin
		if (!rst_n || !enable) begin
			// dropping enable behaves like reset for the aligner
			state <= st_idle;
			bitslip <= 1'b0;
			slip_count <= '0;
			match_count <= '0;
			settle_count <= '0;
		end else begin
			bitslip <= 1'b0; // pulse only
			case (state)
				st_idle: begin
					state <= st_hunting; // enable just rose
					match_count <= '0;
				end

				st_hunting: begin
					if (word_valid) begin
						if (match) begin
							if (match_count == match_count_width'(lock_matches - 1)) begin
								state <= st_locked; // locked shows up next cycle
							end else begin
								match_count <= match_count + 1'b1;
							end
						end else begin
							// wrong boundary, move it one bit later
							match_count <= '0;
							bitslip <= 1'b1;
							settle_count <= settle_count_width'(slip_settle_words);
							state <= st_settling;
							if (!slips_full) begin
								slip_count <= slip_count + 1'b1; // saturates at all ones
							end
						end
					end
				end

				st_settling: begin
					// the first words after a slip are not trusted
					if (word_valid) begin
						settle_count <= settle_count - 1'b1;
						if (settle_count == settle_count_width'(1)) begin
							state <= st_hunting;
						end
					end
				end

				st_locked: begin
					state <= st_locked; // held until enable falls
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

//--- design/deser_apb_regs.sv
`timescale 1ns/100ps

module deser_apb_regs import serdes_pkg::*, apb_map_pkg::*; (
	input bit_clock,
	input rst_n,
	// APB slave, no wait states
	input psel,
	input penable,
	input pwrite,
	input [apb_addr_width-1:0] paddr,
	input [apb_data_width-1:0] pwdata,
	output logic [apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	// datapath side
	input [word_width-1:0] word,
	input word_valid,
	input locked,
	input [slip_count_width-1:0] slip_count,
	output logic enable,
	output logic [word_width-1:0] pattern
);
	logic setup; // first cycle of a transfer
	logic access; // second cycle, write commits at its end
	logic wr_ctrl;
	logic mapped;
	logic read_only;
	logic err;
	logic [apb_data_width-1:0] rd_mux;
	logic [word_width-1:0] last_word;
	logic [count_width-1:0] word_count;

	assign setup = psel && !penable;
	assign access = psel && penable;
	assign pready = psel; // always ready

	// address decode and read mux
	always_comb begin
		mapped = 1'b1;
		read_only = 1'b1;
		rd_mux = '0;
		case (paddr)
			reg_ctrl: begin
				read_only = 1'b0;
				rd_mux[ctrl_enable_bit] = enable;
				rd_mux[ctrl_pattern_lsb +: word_width] = pattern;
			end
			reg_status: begin
				rd_mux[status_locked_bit] = locked;
				rd_mux[status_slips_lsb +: slip_count_width] = slip_count;
			end
			reg_data: begin
				rd_mux[word_width-1:0] = last_word;
			end
			reg_count: begin
				rd_mux[count_width-1:0] = word_count;
			end
			default: begin
				mapped = 1'b0; // unaligned or unknown offset
			end
		endcase
	end

	assign err = !mapped || (pwrite && read_only);
	// only a mapped write to reg_ctrl changes anything
	assign wr_ctrl = access && pwrite && (paddr == reg_ctrl);

	// response registered at the end of setup so it is valid in access
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			pslverr <= 1'b0;
		end else if (setup) begin
			pslverr <= err;
		end else if (!psel) begin
			pslverr <= 1'b0; // idle bus
		end
	end

	always_ff @(posedge bit_clock) begin
		if (setup) begin
			prdata <= rd_mux;
		end
	end

	// control register
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			enable <= 1'b0;
			pattern <= '0;
		end else if (wr_ctrl) begin
			enable <= pwdata[ctrl_enable_bit];
			pattern <= pwdata[ctrl_pattern_lsb +: word_width];
		end
	end

	// last word seen, one cycle after word_valid
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			last_word <= '0;
		end else if (word_valid) begin
			last_word <= word;
		end
	end

	// words since lock
	always_ff @(posedge bit_clock) begin
		if (!rst_n || !locked) begin
			word_count <= '0; // cleared whenever lock is down
		end else if (word_valid) begin
			word_count <= word_count + 1'b1; // wraps at 16 bits
		end
	end

endmodule

//--- design/deser_top.sv
`timescale 1ns/100ps

module deser_top import serdes_pkg::*, apb_map_pkg::*; (
	input bit_clock,
	input rst_n,
	input input_bit, // serial data in
	// APB slave
	input psel,
	input penable,
	input pwrite,
	input [apb_addr_width-1:0] paddr,
	input [apb_data_width-1:0] pwdata,
	output logic [apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	// recovered words
	output logic [word_width-1:0] word,
	output logic word_valid,
	output logic locked
);
	logic bitslip; // aligner back to deserializer
	logic enable;
	logic [word_width-1:0] pattern;
	logic [slip_count_width-1:0] slip_count;

	bit_deserializer i_deser (
		.bit_clock(bit_clock),
		.rst_n(rst_n),
		.input_bit(input_bit),
		.bitslip(bitslip),
		.word(word),
		.word_valid(word_valid)
	);

	word_aligner i_aligner (
		.bit_clock(bit_clock),
		.rst_n(rst_n),
		.enable(enable),
		.pattern(pattern),
		.word(word),
		.word_valid(word_valid),
		.bitslip(bitslip),
		.locked(locked),
		.slip_count(slip_count)
	);

	// control and status over APB
	deser_apb_regs i_regs (
		.bit_clock(bit_clock),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.word(word),
		.word_valid(word_valid),
		.locked(locked),
		.slip_count(slip_count),
		.enable(enable),
		.pattern(pattern)
	);

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic bit_clock,
	output logic rst_n
);
	initial begin
		bit_clock = 1'b0;
		rst_n = 1'b0; // held low from time zero
		repeat (4) @(posedge bit_clock);
		@(negedge bit_clock);
		rst_n = 1'b1; // released away from the sampling edge
	end

	// 4 ns period
	always #2 bit_clock = ~bit_clock;

endmodule

//--- sim/deser_checker.sv
`timescale 1ns/100ps

module deser_checker import serdes_pkg::*, apb_map_pkg::*; (
	input bit_clock,
	input rst_n,
	input psel,
	input penable,
	input [apb_data_width-1:0] prdata,
	input pready,
	input pslverr,
	input [word_width-1:0] word,
	input word_valid,
	input locked
);
	int word_errors = 0;
	int apb_errors = 0;
	logic [word_width-1:0] exp_words[$]; // words still on their way through the DUT
	logic apb_pending = 1'b0;
	logic apb_is_read;
	logic [apb_data_width-1:0] apb_data;
	logic apb_err;
	logic reset_checked = 1'b0;

	task automatic expect_word(input logic [word_width-1:0] w);
		exp_words.push_back(w);
	endtask

	task automatic expect_apb(input logic is_read, input logic [apb_data_width-1:0] data,
			input logic err);
		apb_pending = 1'b1;
		apb_is_read = is_read;
		apb_data = data;
		apb_err = err;
	endtask

	function automatic int pending_words();
		return exp_words.size();
	endfunction

	function automatic logic apb_left();
		return apb_pending;
	endfunction

	// everything is sampled on the rising edge while inputs change on the falling one
	always @(posedge bit_clock) begin
		logic [word_width-1:0] w;
		if (rst_n) begin
			if (!reset_checked) begin
				reset_checked = 1'b1;
				if (locked !== 1'b0 || word_valid !== 1'b0) begin
					$display("FAIL %0t: locked %b word_valid %b after reset", $time, locked,
						word_valid);
					word_errors++;
				end
			end
			// only words the testbench announced are compared
			if (word_valid === 1'b1 && exp_words.size() > 0) begin
				w = exp_words.pop_front();
				if (word !== w) begin
					$display("FAIL %0t: word %h, expected %h", $time, word, w);
					word_errors++;
				end
				if (locked !== 1'b1) begin
					$display("FAIL %0t: locked low while data words arrive", $time);
					word_errors++;
				end
			end
			// APB access cycle
			if (psel && penable) begin
				if (!apb_pending) begin
					$display("access cycle with no expected response at %0t", $time);
					apb_errors++;
				end else begin
					apb_pending = 1'b0;
					if (pready !== 1'b1) begin
						$display("FAIL %0t: pready low in access cycle", $time);
						apb_errors++;
					end
					if (pslverr !== apb_err) begin
						$display("FAIL %0t: pslverr %b, expected %b", $time, pslverr, apb_err);
						apb_errors++;
					end
					if (apb_is_read && prdata !== apb_data) begin
						$display("FAIL %0t: prdata %h, expected %h", $time, prdata, apb_data);
						apb_errors++;
					end
				end
			end
		end
	end

endmodule

//--- sim/deser_tb.sv
`timescale 1ns/100ps

module deser_tb import serdes_pkg::*, apb_map_pkg::*;;
	localparam int timeout_margin = 200;
	localparam int max_cmds = 256;

	logic bit_clock;
	logic rst_n;
	logic input_bit = 1'b0;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	logic [apb_addr_width-1:0] paddr = '0;
	logic [apb_data_width-1:0] pwdata = '0;
	logic [apb_data_width-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [word_width-1:0] word;
	logic word_valid;
	logic locked;

	// parsed test file
	byte cmd_op[max_cmds];
	logic [31:0] cmd_a[max_cmds];
	logic [31:0] cmd_b[max_cmds];
	logic [31:0] cmd_c[max_cmds];
	int num_cmds = 0;

	int tb_errors = 0;
	int cycles = 0;
	int limit = 32'h7fffffff; // replaced once the file is read
	int seed = 95261;
	int tick_no = 0;

	// reference framing of the received stream while the model is locked
	logic model_locked = 1'b0;
	int frame_cnt = 0;
	logic [word_width-1:0] frame = '0;
	int push_tick[$];
	logic [word_width-1:0] push_word[$];

	tb_clock_gen i_clk (.bit_clock(bit_clock), .rst_n(rst_n));

	deser_top i_dut (
		.bit_clock(bit_clock), .rst_n(rst_n), .input_bit(input_bit),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.word(word), .word_valid(word_valid), .locked(locked)
	);

	deser_checker i_chk (
		.bit_clock(bit_clock), .rst_n(rst_n), .psel(psel), .penable(penable),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.word(word), .word_valid(word_valid), .locked(locked)
	);

	// one bit time with the serial line driven on the falling edge
	task automatic tick(input logic b);
		@(negedge bit_clock);
		tick_no++;
		input_bit = b;
		if (model_locked) begin
			frame = {frame[word_width-2:0], b}; // msb arrives first
			frame_cnt++;
			if (frame_cnt == word_width) begin
				frame_cnt = 0;
				push_tick.push_back(tick_no);
				push_word.push_back(frame);
				i_chk.expect_word(frame);
			end
		end
	endtask

	task automatic send_word(input logic [word_width-1:0] w);
		for (int i = word_width - 1; i >= 0; i--) begin
			tick(w[i]);
		end
	endtask

	// kind selects a fixed expectation (0), the word count (1) or the last word (2)
	task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
			input logic err, input int kind);
		logic [31:0] exp;
		int n;
		exp = data;
		if (wr && !err && addr == 32'h0 && !data[0]) begin
			model_locked = 1'b0; // no words are expected once the receiver is off
		end
		tick(1'b0);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr[apb_addr_width-1:0];
		pwdata = wr ? data : '0;
		// a word lands in the registers two edges after its strobe
		if (kind == 1) begin
			n = 0;
			foreach (push_tick[i]) begin
				if (push_tick[i] <= tick_no - 3) begin
					n++;
				end
			end
			exp = 32'(n);
		end else if (kind == 2) begin
			n = -1;
			foreach (push_tick[i]) begin
				if (push_tick[i] <= tick_no - 3) begin
					n = i;
				end
			end
			if (n < 0) begin
				$display("reg_data read with no word received since lock at %0t", $time);
				tb_errors++;
				exp = '0;
			end else begin
				exp = 32'(push_word[n]);
			end
		end
		i_chk.expect_apb(!wr, exp, err);
		tick(1'b0);
		penable = 1'b1;
		tick(1'b0);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// training waits for a boundary, then sends k tail bits and the pattern repeated
	task automatic train(input int k, input logic [word_width-1:0] pat, input int reps);
		int nbits;
		int lock_bit;
		tick(1'b0);
		while (word_valid !== 1'b1) tick(1'b0);
		repeat (3) tick(1'b0); // next bit starts a word
		nbits = k + word_width * reps;
		// each of the k slips costs 3 words and one bit before the 4 matches
		lock_bit = k + word_width * (3 * k + lock_matches);
		for (int j = 0; j < nbits; j++) begin
			if (j == lock_bit) begin
				model_locked = 1'b1;
				frame_cnt = 0;
				push_tick.delete();
				push_word.delete();
			end
			tick(pat[word_width - 1 - ((j + word_width - k) % word_width)]);
			if (j == 0) begin
				psel = 1'b1; // enable write with the new pattern
				pwrite = 1'b1;
				paddr = '0;
				pwdata = 32'(pat) << 8 | 32'h1;
				i_chk.expect_apb(1'b0, '0, 1'b0);
			end else if (j == 1) begin
				penable = 1'b1;
			end else if (j == 2) begin
				psel = 1'b0;
				penable = 1'b0;
				pwrite = 1'b0;
			end
		end
	endtask

	task automatic read_tests();
		int fd;
		int code;
		logic [8*16-1:0] tok;
		logic [8*128-1:0] rest;
		fd = $fopen("sim/deser_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/deser_tests.txt");
			tb_errors++;
			return;
		end
		while (!$feof(fd) && num_cmds < max_cmds) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) break;
			if (tok[7:0] == "#") begin
				code = $fgets(rest, fd); // column notes
			end else begin
				cmd_op[num_cmds] = tok[7:0];
				cmd_a[num_cmds] = '0;
				cmd_b[num_cmds] = '0;
				cmd_c[num_cmds] = '0;
				case (tok[7:0])
					"W", "R", "T": code = $fscanf(fd, "%h %h %h", cmd_a[num_cmds],
						cmd_b[num_cmds], cmd_c[num_cmds]);
					"D", "X", "I": code = $fscanf(fd, "%h", cmd_a[num_cmds]);
					default: ;
				endcase
				num_cmds++;
			end
		end
		$fclose(fd);
	endtask

	// run limit from the length of the tests
	always @(posedge bit_clock) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		int bits;
		int apb_cmds;
		int total;
		logic [31:0] rnd;
		read_tests();
		bits = 0;
		apb_cmds = 0;
		for (int i = 0; i < num_cmds; i++) begin
			case (cmd_op[i])
				"T": bits += 10 + int'(cmd_a[i]) + word_width * int'(cmd_c[i]);
				"D": bits += word_width * int'(cmd_a[i]);
				"X": bits += word_width;
				"I": bits += int'(cmd_a[i]);
				default: apb_cmds++;
			endcase
		end
		bits += 12; // final drain
		limit = 5 * bits + 4 * apb_cmds + timeout_margin;
		@(posedge rst_n);
		for (int i = 0; i < num_cmds; i++) begin
			case (cmd_op[i])
				"W": apb_xfer(1'b1, cmd_a[i], cmd_b[i], cmd_c[i][0], 0);
				"R": apb_xfer(1'b0, cmd_a[i], cmd_b[i], cmd_c[i][0], 0);
				"C": apb_xfer(1'b0, 32'hC, '0, 1'b0, 1);
				"L": apb_xfer(1'b0, 32'h8, '0, 1'b0, 2);
				"T": train(int'(cmd_a[i]), cmd_b[i][word_width-1:0], int'(cmd_c[i]));
				"X": send_word(cmd_a[i][word_width-1:0]);
				"D": for (int n = 0; n < int'(cmd_a[i]); n++) begin
					rnd = $random(seed);
					send_word(rnd[word_width-1:0]);
				end
				"I": repeat (int'(cmd_a[i])) tick(1'b0);
				default: begin
					$display("unknown command in test file");
					tb_errors++;
				end
			endcase
		end
		model_locked = 1'b0;
		repeat (12) tick(1'b0); // let the last words come out
		if (i_chk.pending_words() != 0 || i_chk.apb_left()) begin
			$display("expected responses never arrived");
			tb_errors++;
		end
		total = i_chk.word_errors + i_chk.apb_errors + tb_errors;
		$display("errors: word %0d apb %0d other %0d", i_chk.word_errors, i_chk.apb_errors,
			tb_errors);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- sim/deser_tests.txt
# W addr data err | R addr data err | C count read | L last word read (values in hex)
# T offset pattern repeats | D random words | X one word | I idle cycles
R 0 00000000 0
R 4 00000000 0
R 8 00000000 0
R C 00000000 0
W 0 00001500 0
R 0 00001500 0
W 4 00000001 1
W 6 00001f01 1
R 6 00000000 1
R 0 00001500 0
R 4 00000000 0
T 0 15 14
R 4 00000001 0
X 0a
D 10
I 3
L
C
W 0 00001500 0
R 4 00000000 0
T 1 0d 14
R 4 00000101 0
D 8
I 2
L
C
W 0 00000d00 0
R 4 00000000 0
T 2 0b 14
R 4 00000201 0
X 1c
I 3
L
W 0 00000b00 0
T 3 19 14
R 4 00000301 0
D 6
C
W 0 00001900 0
R 4 00000000 0
T 4 07 14
R 4 00000401 0
D 12
X 13
I 3
L
C

//--- compile.f
design/serdes_pkg.sv
design/apb_map_pkg.sv
design/bit_deserializer.sv
design/word_aligner.sv
design/deser_apb_regs.sv
design/deser_top.sv
sim/tb_clock_gen.sv
sim/deser_checker.sv
sim/deser_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= deser_tb
FILELIST ?= compile.f
LOG ?= sim.log
OBJ_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
